/* project.f */
rtl/periph_pkg.sv
rtl/gpio_regs.sv
rtl/pwm_regs.sv
rtl/dev_bus_decode.sv
rtl/periph_top.sv
testbench/tb_periph.sv

/* rtl/dev_bus_decode.sv */
// Bus decoder: window select, request steering, response merge and unmapped-access errors.
`timescale 1ns/1ps

module dev_bus_decode (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,
  input  logic                                 bus_req_i,
  input  logic                                 bus_we_i,
  input  logic [periph_pkg::BusAddrWidth-1:0]  bus_addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] bus_be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  bus_wdata_i,
  input  logic                                 gpio_rvalid_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  gpio_rdata_i,
  input  logic                                 pwm_rvalid_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  pwm_rdata_i,
  output logic                                 gpio_req_o,
  output logic                                 pwm_req_o,
  output logic                                 dev_we_o,
  output logic [periph_pkg::RegAddrWidth-1:0]  dev_addr_o,
  output logic [periph_pkg::BusByteEnable-1:0] dev_be_o,
  output logic [periph_pkg::BusDataWidth-1:0]  dev_wdata_o,
  output logic                                 bus_rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  bus_rdata_o,
  output logic                                 bus_err_o
);
  import periph_pkg::*;

  dev_sel_e dev_sel_d;
  dev_sel_e dev_sel_q;
  logic     req_q;

  ////////////////////
  // Request path.
  ////////////////////

  always_comb begin
    if ((bus_addr_i & DevWinMask) == GpioBase) begin
      dev_sel_d = DevGpio;
    end else if ((bus_addr_i & DevWinMask) == PwmBase) begin
      dev_sel_d = DevPwm;
    end else begin
      dev_sel_d = DevNone;
    end
  end

  assign gpio_req_o  = bus_req_i & (dev_sel_d == DevGpio);
  assign pwm_req_o   = bus_req_i & (dev_sel_d == DevPwm);
  assign dev_we_o    = bus_we_i;
  assign dev_addr_o  = bus_addr_i[RegAddrWidth-1:0];
  assign dev_be_o    = bus_be_i;
  assign dev_wdata_o = bus_wdata_i;

  // Target of the access now returning.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q     <= 1'b0;
      dev_sel_q <= DevNone;
    end else begin
      req_q     <= bus_req_i;
      dev_sel_q <= dev_sel_d;
    end
  end

  ////////////////////
  // Response path.
  ////////////////////

  always_comb begin
    bus_rvalid_o = 1'b0;
    bus_rdata_o  = '0;
    bus_err_o    = 1'b0;
    case (dev_sel_q)
      DevGpio: begin
        bus_rvalid_o = req_q & gpio_rvalid_i;
        bus_rdata_o  = gpio_rdata_i;
      end
      DevPwm: begin
        bus_rvalid_o = req_q & pwm_rvalid_i;
        bus_rdata_o  = pwm_rdata_i;
      end
      default: begin
        // Unmapped, answer with an error and zero data.
        bus_rvalid_o = req_q;
        bus_err_o    = req_q;
      end
    endcase
  end

  // Device responses come back exactly one cycle after their own request.
  a_gpio_rvalid_after_req: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    gpio_rvalid_i |-> $past(gpio_req_o));
  a_pwm_rvalid_after_req: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    pwm_rvalid_i |-> $past(pwm_req_o));
  a_rvalid_onehot: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    !(gpio_rvalid_i && pwm_rvalid_i));

endmodule

/* rtl/gpio_regs.sv */
// GPIO register block: byte-writable output register and two-flop synchronized input.
`timescale 1ns/1ps

module gpio_regs #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [periph_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  wdata_i,
  input  logic [GpiWidth-1:0]                  gp_i,
  output logic                                 rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  rdata_o,
  output logic [GpoWidth-1:0]                  gp_o
);
  import periph_pkg::*;

  logic [GpoWidth-1:0]     gpo_q;
  logic [GpiWidth-1:0]     gpi_meta_q;
  logic [GpiWidth-1:0]     gpi_sync_q;
  logic [BusDataWidth-1:0] be_mask;
  logic                    gpo_we;
  logic [BusDataWidth-1:0] rdata_d;

  // Expand byte enables to a bit mask.
  always_comb begin
    for (int b = 0; b < BusByteEnable; b++) begin
      be_mask[b*8 +: 8] = {8{be_i[b]}};
    end
  end

  assign gpo_we = req_i & we_i & (addr_i == GpoOffset);

  always_comb begin
    rdata_d = '0;
    if (addr_i == GpoOffset) begin
      rdata_d = BusDataWidth'(gpo_q);
    end else if (addr_i == GpiOffset) begin
      rdata_d = BusDataWidth'(gpi_sync_q);
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_o   <= req_i;
      if (req_i) begin
        rdata_o <= rdata_d;
      end
      // Only enabled bytes change.
      if (gpo_we) begin
        gpo_q <= (gpo_q & ~be_mask[GpoWidth-1:0]) |
                 (wdata_i[GpoWidth-1:0] & be_mask[GpoWidth-1:0]);
      end
    end
  end

  assign gp_o = gpo_q;

endmodule

/* rtl/periph_pkg.sv */
// Shared bus widths, peripheral address map, register offsets and device select type.
package periph_pkg;

  ////////////////////
  // Bus widths.
  ////////////////////

  parameter int unsigned BusAddrWidth  = 32;
  parameter int unsigned BusDataWidth  = 32;
  parameter int unsigned BusByteEnable = 4;

  // Offset inside one device window, 256 bytes each.
  parameter int unsigned RegAddrWidth  = 8;

  ////////////////////
  // Address map.
  ////////////////////

  parameter logic [BusAddrWidth-1:0] GpioBase   = 32'h8000_0000;
  parameter logic [BusAddrWidth-1:0] PwmBase    = 32'h8000_1000;
  parameter logic [BusAddrWidth-1:0] DevWinMask =
      {{(BusAddrWidth - RegAddrWidth){1'b1}}, {RegAddrWidth{1'b0}}};

  // GPIO registers.
  parameter logic [RegAddrWidth-1:0] GpoOffset = 8'h0;
  parameter logic [RegAddrWidth-1:0] GpiOffset = 8'h4;

  // PWM channel register pairs.
  parameter int unsigned             PwmChanStride   = 8;
  parameter logic [RegAddrWidth-1:0] PwmDutyOffset   = 8'h0;
  parameter logic [RegAddrWidth-1:0] PwmPeriodOffset = 8'h4;

  // Target of one bus access.
  typedef enum logic [1:0] {
    DevGpio = 2'd0,
    DevPwm  = 2'd1,
    DevNone = 2'd2
  } dev_sel_e;

endpackage

/* rtl/periph_top.sv */
// Peripheral top level: bus decoder with GPIO and PWM register blocks.
`timescale 1ns/1ps

module periph_top #(
  parameter int unsigned GpiWidth   = 13,
  parameter int unsigned GpoWidth   = 24,
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,
  input  logic                                 bus_req_i,
  input  logic                                 bus_we_i,
  input  logic [periph_pkg::BusAddrWidth-1:0]  bus_addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] bus_be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  bus_wdata_i,
  input  logic [GpiWidth-1:0]                  gp_i,
  output logic                                 bus_rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  bus_rdata_o,
  output logic                                 bus_err_o,
  output logic [GpoWidth-1:0]                  gp_o,
  output logic [PwmWidth-1:0]                  pwm_o
);
  import periph_pkg::*;

  // Shared device request lines.
  logic                     gpio_req;
  logic                     pwm_req;
  logic                     dev_we;
  logic [RegAddrWidth-1:0]  dev_addr;
  logic [BusByteEnable-1:0] dev_be;
  logic [BusDataWidth-1:0]  dev_wdata;

  // Device responses.
  logic                     gpio_rvalid;
  logic [BusDataWidth-1:0]  gpio_rdata;
  logic                     pwm_rvalid;
  logic [BusDataWidth-1:0]  pwm_rdata;

  dev_bus_decode u_decode (
    .clk_sys_i    (clk_sys_i),
    .arst_n_i     (arst_n_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_be_i     (bus_be_i),
    .bus_wdata_i  (bus_wdata_i),
    .gpio_rvalid_i(gpio_rvalid),
    .gpio_rdata_i (gpio_rdata),
    .pwm_rvalid_i (pwm_rvalid),
    .pwm_rdata_i  (pwm_rdata),
    .gpio_req_o   (gpio_req),
    .pwm_req_o    (pwm_req),
    .dev_we_o     (dev_we),
    .dev_addr_o   (dev_addr),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_err_o    (bus_err_o)
  );

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .req_i    (gpio_req),
    .we_i     (dev_we),
    .addr_i   (dev_addr),
    .be_i     (dev_be),
    .wdata_i  (dev_wdata),
    .gp_i     (gp_i),
    .rvalid_o (gpio_rvalid),
    .rdata_o  (gpio_rdata),
    .gp_o     (gp_o)
  );

  pwm_regs #(
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize)
  ) u_pwm (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .req_i    (pwm_req),
    .we_i     (dev_we),
    .addr_i   (dev_addr),
    .be_i     (dev_be),
    .wdata_i  (dev_wdata),
    .rvalid_o (pwm_rvalid),
    .rdata_o  (pwm_rdata),
    .pwm_o    (pwm_o)
  );

endmodule

/* rtl/pwm_regs.sv */
// PWM register block: per-channel duty and period registers with free-running counters.
`timescale 1ns/1ps

module pwm_regs #(
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [periph_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  wdata_i,
  output logic                                 rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  rdata_o,
  output logic [PwmWidth-1:0]                  pwm_o
);
  import periph_pkg::*;

  localparam int unsigned ChanShift = $clog2(PwmChanStride);
  localparam int unsigned ChanIdxW  = RegAddrWidth - ChanShift;

  logic [PwmCtrSize-1:0]   duty_q   [PwmWidth];
  logic [PwmCtrSize-1:0]   period_q [PwmWidth];
  logic [PwmCtrSize-1:0]   ctr_q    [PwmWidth];
  logic [PwmWidth-1:0]     duty_we;
  logic [PwmWidth-1:0]     period_we;
  logic [ChanIdxW-1:0]     chan_idx;
  logic [ChanShift-1:0]    sub_off;
  logic                    wr_en;
  logic [BusDataWidth-1:0] rdata_d;

  ////////////////////
  // Address decode.
  ////////////////////

  assign chan_idx = addr_i[RegAddrWidth-1:ChanShift];
  assign sub_off  = addr_i[ChanShift-1:0];

  // Registers hold one byte, so byte lane 0 gates writes.
  assign wr_en = req_i & we_i & be_i[0];

  ////////////////////
  // Channels.
  ////////////////////

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    assign duty_we[i]   = wr_en & (chan_idx == ChanIdxW'(i)) &
                          (sub_off == PwmDutyOffset[ChanShift-1:0]);
    assign period_we[i] = wr_en & (chan_idx == ChanIdxW'(i)) &
                          (sub_off == PwmPeriodOffset[ChanShift-1:0]);

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        duty_q[i]   <= '0;
        period_q[i] <= '0;
        ctr_q[i]    <= '0;
      end else begin
        if (duty_we[i]) begin
          duty_q[i] <= wdata_i[PwmCtrSize-1:0];
        end
        // New period restarts the cycle.
        if (period_we[i]) begin
          period_q[i] <= wdata_i[PwmCtrSize-1:0];
          ctr_q[i]    <= '0;
        end else if (ctr_q[i] == period_q[i]) begin
          ctr_q[i] <= '0;
        end else begin
          ctr_q[i] <= ctr_q[i] + 1'b1;
        end
      end
    end

    assign pwm_o[i] = ctr_q[i] < duty_q[i];

    // Counter wraps at the period.
    a_ctr_in_period: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
      ctr_q[i] <= period_q[i]);
  end

  ////////////////////
  // Read response.
  ////////////////////

  // Offsets past the last channel match nothing and read zero.
  always_comb begin
    rdata_d = '0;
    for (int c = 0; c < PwmWidth; c++) begin
      if (chan_idx == ChanIdxW'(c)) begin
        if (sub_off == PwmDutyOffset[ChanShift-1:0]) begin
          rdata_d = BusDataWidth'(duty_q[c]);
        end else if (sub_off == PwmPeriodOffset[ChanShift-1:0]) begin
          rdata_d = BusDataWidth'(period_q[c]);
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= req_i;
      if (req_i) begin
        rdata_o <= rdata_d;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the peripheral testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
TOP=tb_periph

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -f project.f \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG_FILE"; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "Test OK" "$LOG_FILE"; then
  echo "Simulation ended without a result line"
  exit 1
fi

echo "Simulation passed"
exit 0

/* testbench/tb_periph.sv */
// Testbench for the peripheral top level: clock, reset, bus tasks, assertions and watchdog.
`timescale 1ns/1ps

module tb_periph;
  import periph_pkg::*;

  localparam int unsigned GpiWidth     = 13;
  localparam int unsigned GpoWidth     = 24;
  localparam int unsigned PwmWidth     = 12;
  localparam int unsigned ChIdxW       = $clog2(PwmWidth);
  localparam int unsigned ClkPeriodNs  = 40;
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned NumGpoWrites = 40;
  localparam int unsigned NumGpiReads  = 8;
  localparam int unsigned NumPwmCfgs   = 4;
  localparam int unsigned MaxPeriod    = 40;
  localparam int unsigned PwmWindows   = 3;
  // Sum of the test lengths in cycles, plus a margin.
  localparam int unsigned TimeoutCycles = ResetCycles + 6 + NumGpoWrites * 3 + 4 +
      NumGpiReads * 5 + 4 + NumPwmCfgs * ((MaxPeriod + 1) * PwmWindows + 8) + 12 + 200;

  localparam logic [BusAddrWidth-1:0] GpoAddr = GpioBase + BusAddrWidth'(GpoOffset);
  localparam logic [BusAddrWidth-1:0] GpiAddr = GpioBase + BusAddrWidth'(GpiOffset);

  logic                     clk_sys;
  logic                     arst_n;
  logic                     bus_req;
  logic                     bus_we;
  logic [BusAddrWidth-1:0]  bus_addr;
  logic [BusByteEnable-1:0] bus_be;
  logic [BusDataWidth-1:0]  bus_wdata;
  logic [GpiWidth-1:0]      gp_in;
  logic                     bus_rvalid;
  logic [BusDataWidth-1:0]  bus_rdata;
  logic                     bus_err;
  logic [GpoWidth-1:0]      gp_out;
  logic [PwmWidth-1:0]      pwm_out;

  // Expected response of the access in flight.
  logic                     nxt_chk;
  logic [BusDataWidth-1:0]  nxt_rdata;
  logic                     nxt_err;
  logic                     cur_valid;
  logic                     cur_chk;
  logic [BusDataWidth-1:0]  cur_rdata;
  logic                     cur_err;
  logic [GpoWidth-1:0]      gpo_model;
  logic [GpoWidth-1:0]      exp_gpo;
  logic                     post_rst;

  // PWM high-count monitor.
  logic                     mon_en;
  logic [ChIdxW-1:0]        mon_ch;
  int unsigned              mon_p;
  int unsigned              mon_exp;
  int unsigned              mon_hi = 0;
  int unsigned              mon_cyc = 0;
  int unsigned              win_hi = 0;
  logic                     win_done = 1'b0;

  int unsigned              fail_reset = 0;
  int unsigned              fail_rvalid = 0;
  int unsigned              fail_rdata = 0;
  int unsigned              fail_err = 0;
  int unsigned              fail_gpo = 0;
  int unsigned              fail_pwm = 0;
  int unsigned              test_cnt = 0;

  always #20 clk_sys = ~clk_sys;

  periph_top dut0 (
    .clk_sys_i   (clk_sys),
    .arst_n_i    (arst_n),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_be_i    (bus_be),
    .bus_wdata_i (bus_wdata),
    .gp_i        (gp_in),
    .bus_rvalid_o(bus_rvalid),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err),
    .gp_o        (gp_out),
    .pwm_o       (pwm_out)
  );

  // Expectations move with the request into the response cycle.
  always @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      cur_valid <= 1'b0;
      cur_chk   <= 1'b0;
      cur_rdata <= '0;
      cur_err   <= 1'b0;
      exp_gpo   <= '0;
    end else begin
      cur_valid <= bus_req;
      cur_chk   <= nxt_chk;
      cur_rdata <= nxt_rdata;
      cur_err   <= nxt_err;
      exp_gpo   <= gpo_model;
    end
  end

  // Counts high cycles of one channel per window of P+1 cycles.
  always @(negedge clk_sys) begin
    win_done = 1'b0;
    if (!mon_en) begin
      mon_hi  = 0;
      mon_cyc = 0;
    end else begin
      if (pwm_out[mon_ch]) begin
        mon_hi = mon_hi + 1;
      end
      mon_cyc = mon_cyc + 1;
      if (mon_cyc == mon_p + 1) begin
        win_done = 1'b1;
        win_hi   = mon_hi;
        mon_hi   = 0;
        mon_cyc  = 0;
      end
    end
  end

  ////////////////////
  // Assertions.
  ////////////////////

  a_reset_zero: assert property (@(negedge clk_sys)
      (!arst_n || post_rst) |-> (!bus_rvalid && !bus_err && gp_out == '0 && pwm_out == '0))
    else begin
      $display("Fail reset: bus_rvalid_o %h bus_err_o %h gp_o %h pwm_o %h, expected all 0",
               bus_rvalid, bus_err, gp_out, pwm_out);
      fail_reset = fail_reset + 1;
    end

  a_rvalid: assert property (@(negedge clk_sys) disable iff (!arst_n)
      bus_rvalid == cur_valid)
    else begin
      $display("Fail bus_rvalid_o: expected %h, got %h", cur_valid, bus_rvalid);
      fail_rvalid = fail_rvalid + 1;
    end

  a_rdata: assert property (@(negedge clk_sys) disable iff (!arst_n)
      (bus_rvalid && cur_chk) |-> (bus_rdata == cur_rdata))
    else begin
      $display("Fail bus_rdata_o: expected %h, got %h", cur_rdata, bus_rdata);
      fail_rdata = fail_rdata + 1;
    end

  a_err: assert property (@(negedge clk_sys) disable iff (!arst_n)
      bus_err == (cur_valid && cur_err))
    else begin
      $display("Fail bus_err_o: expected %h, got %h", cur_valid && cur_err, bus_err);
      fail_err = fail_err + 1;
    end

  a_gpo: assert property (@(negedge clk_sys) disable iff (!arst_n)
      gp_out == exp_gpo)
    else begin
      $display("Fail gp_o: expected %h, got %h", exp_gpo, gp_out);
      fail_gpo = fail_gpo + 1;
    end

  a_pwm_high_count: assert property (@(posedge clk_sys) disable iff (!arst_n)
      win_done |-> (win_hi == mon_exp))
    else begin
      $display("Fail pwm_o[%0d] high cycles: expected %h, got %h", mon_ch, mon_exp, win_hi);
      fail_pwm = fail_pwm + 1;
    end

  ////////////////////
  // Helpers.
  ////////////////////

  function automatic int unsigned total_errors();
    return fail_reset + fail_rvalid + fail_rdata + fail_err + fail_gpo + fail_pwm;
  endfunction

  function automatic logic [GpoWidth-1:0] merge_bytes(input logic [GpoWidth-1:0] old,
      input logic [BusDataWidth-1:0] wdata, input logic [BusByteEnable-1:0] be);
    logic [BusDataWidth-1:0] full;
    full = BusDataWidth'(old);
    for (int b = 0; b < BusByteEnable; b++) begin
      if (be[b]) begin
        full[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return full[GpoWidth-1:0];
  endfunction

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk_sys);
      #2;
    end
  endtask

  // One strobe, with the response expected in the next cycle.
  task automatic bus_access(input logic we, input logic [BusAddrWidth-1:0] addr,
      input logic [BusByteEnable-1:0] be, input logic [BusDataWidth-1:0] wdata,
      input logic chk, input logic [BusDataWidth-1:0] exp_rdata, input logic exp_err);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_be    = be;
    bus_wdata = wdata;
    nxt_chk   = chk;
    nxt_rdata = exp_rdata;
    nxt_err   = exp_err;
    @(posedge clk_sys);
    #2;
    bus_req = 1'b0;
    nxt_chk = 1'b0;
    nxt_err = 1'b0;
  endtask

  task automatic read_check(input logic [BusAddrWidth-1:0] addr,
      input logic [BusDataWidth-1:0] exp_rdata);
    bus_access(1'b0, addr, 4'hf, '0, 1'b1, exp_rdata, 1'b0);
  endtask

  task automatic write_gpo(input logic [BusByteEnable-1:0] be,
      input logic [BusDataWidth-1:0] wdata);
    gpo_model = merge_bytes(gpo_model, wdata, be);
    bus_access(1'b1, GpoAddr, be, wdata, 1'b0, '0, 1'b0);
  endtask

  task automatic unmapped_access(input logic we, input logic [BusAddrWidth-1:0] addr);
    bus_access(we, addr, 4'hf, $urandom, 1'b1, '0, 1'b1);
  endtask

  task automatic report_test(input string name);
    test_cnt = test_cnt + 1;
    $display("[%0d] %s finished, errors so far %0d", test_cnt, name, total_errors());
  endtask

  ////////////////////
  // Stimulus.
  ////////////////////

  initial begin
    logic [GpiWidth-1:0]     gpi_val;
    logic [BusAddrWidth-1:0] pwm_addr;
    int unsigned             ch;
    int unsigned             period;
    int unsigned             duty;
    clk_sys   = 1'b0;
    arst_n    = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_be    = '0;
    bus_wdata = '0;
    gp_in     = '0;
    nxt_chk   = 1'b0;
    nxt_rdata = '0;
    nxt_err   = 1'b0;
    gpo_model = '0;
    post_rst  = 1'b0;
    mon_en    = 1'b0;
    mon_ch    = '0;
    mon_p     = 0;
    mon_exp   = 0;
    ch        = 0;
    period    = 0;
    duty      = 0;
    void'($urandom(32'haada));

    repeat (ResetCycles) @(posedge clk_sys);
    #2;
    arst_n   = 1'b1;
    post_rst = 1'b1;
    idle(4);
    post_rst = 1'b0;
    report_test("reset");

    // Random byte writes, some followed at once by a readback.
    for (int i = 0; i < NumGpoWrites; i++) begin
      write_gpo(BusByteEnable'($urandom), $urandom);
      case ($urandom_range(2, 0))
        0: read_check(GpoAddr, BusDataWidth'(gpo_model));
        1: idle(1);
        default: ;
      endcase
    end
    read_check(GpoAddr, BusDataWidth'(gpo_model));
    idle(2);
    report_test("gpo writes");

    for (int i = 0; i < NumGpiReads; i++) begin
      gpi_val = GpiWidth'($urandom);
      gp_in   = gpi_val;
      idle(3);
      read_check(GpiAddr, BusDataWidth'(gpi_val));
    end
    idle(2);
    report_test("gpi reads");

    // Duty 0, duty above the period, then in-range duties.
    for (int i = 0; i < NumPwmCfgs; i++) begin
      ch     = $urandom_range(PwmWidth - 1, 0);
      period = $urandom_range(MaxPeriod, 1);
      case (i)
        0: duty = 0;
        1: duty = period + 1 + $urandom_range(3, 0);
        default: duty = $urandom_range(period, 1);
      endcase
      pwm_addr = PwmBase + ch * PwmChanStride;
      bus_access(1'b1, pwm_addr + BusAddrWidth'(PwmDutyOffset), 4'h1,
                 ($urandom & 32'hffff_ff00) | duty, 1'b0, '0, 1'b0);
      bus_access(1'b1, pwm_addr + BusAddrWidth'(PwmPeriodOffset), 4'h1,
                 ($urandom & 32'hffff_ff00) | period, 1'b0, '0, 1'b0);
      read_check(pwm_addr + BusAddrWidth'(PwmDutyOffset), duty);
      read_check(pwm_addr + BusAddrWidth'(PwmPeriodOffset), period);
      mon_ch  = ChIdxW'(ch);
      mon_p   = period;
      mon_exp = (duty < period + 1) ? duty : period + 1;
      mon_en  = 1'b1;
      idle((period + 1) * PwmWindows);
      mon_en = 1'b0;
      idle(1);
    end
    idle(2);
    report_test("pwm");

    // Neighbors and aliases of both windows.
    unmapped_access(1'b1, 32'h8000_0100);
    unmapped_access(1'b0, 32'h0000_0004);
    unmapped_access(1'b1, 32'h8100_0000);
    unmapped_access(1'b1, pwm_addr + 32'h0001_0000 + BusAddrWidth'(PwmPeriodOffset));
    unmapped_access(1'b0, 32'h8000_2000);
    read_check(GpoAddr, BusDataWidth'(gpo_model));
    read_check(pwm_addr + BusAddrWidth'(PwmDutyOffset), duty);
    read_check(pwm_addr + BusAddrWidth'(PwmPeriodOffset), period);
    idle(2);
    report_test("unmapped");

    $display("Summary: %0d tests run, %0d errors", test_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriodNs);
    $display("Timeout: the tests did not complete within %0d cycles", TimeoutCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule
